/* hdl/controlPkg.sv */
package controlPkg;

    // Instruction fields and datapath select widths
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [4:0] aluOpT;
    typedef logic [2:0] timerT;
    typedef logic [1:0] srcASelT;
    typedef logic [2:0] srcBSelT;
    typedef logic [2:0] pcSrcT;
    typedef logic [1:0] regDestT;
    typedef logic [2:0] memToRegT;
    typedef logic [2:0] sizeT;
    typedef logic [2:0] addrSelT;

    localparam opcodeT OP_RTYPE = 6'h00;
    localparam opcodeT OP_J     = 6'h02;
    localparam opcodeT OP_JAL   = 6'h03;
    localparam opcodeT OP_BEQ   = 6'h04;
    localparam opcodeT OP_BNE   = 6'h05;
    localparam opcodeT OP_BLE   = 6'h06;
    localparam opcodeT OP_BGT   = 6'h07;
    localparam opcodeT OP_ADDI  = 6'h08;
    localparam opcodeT OP_ADDIU = 6'h09;
    localparam opcodeT OP_SLTI  = 6'h0a;
    localparam opcodeT OP_LB    = 6'h20;
    localparam opcodeT OP_LH    = 6'h21;
    localparam opcodeT OP_LW    = 6'h23;
    localparam opcodeT OP_SB    = 6'h28;
    localparam opcodeT OP_SH    = 6'h29;
    localparam opcodeT OP_SW    = 6'h2b;

    localparam functT FN_JR  = 6'h08;
    localparam functT FN_ADD = 6'h20;
    localparam functT FN_SUB = 6'h22;
    localparam functT FN_AND = 6'h24;
    localparam functT FN_OR  = 6'h25;
    localparam functT FN_SLT = 6'h2a;

    localparam aluOpT ALU_LOAD = 5'd0;             // Pass A through
    localparam aluOpT ALU_OADD = 5'd1;             // Add, flags overflow
    localparam aluOpT ALU_SUB  = 5'd2;
    localparam aluOpT ALU_AND  = 5'd3;
    localparam aluOpT ALU_CMP  = 5'd7;             // Set on less than
    localparam aluOpT ALU_OR   = 5'd8;
    localparam aluOpT ALU_SADD = 5'd11;            // Add, no overflow
    localparam aluOpT ALU_NE   = 5'd14;
    localparam aluOpT ALU_EQ   = 5'd15;
    localparam aluOpT ALU_LE   = 5'd16;
    localparam aluOpT ALU_GT   = 5'd17;

    localparam srcASelT SRC_A_PC  = 2'd0;
    localparam srcASelT SRC_A_REG = 2'd1;

    localparam srcBSelT SRC_B_REG    = 3'd0;
    localparam srcBSelT SRC_B_FOUR   = 3'd1;
    localparam srcBSelT SRC_B_IMM    = 3'd2;
    localparam srcBSelT SRC_B_BRANCH = 3'd3;   // Shifted offset

    localparam pcSrcT PC_SRC_JUMP   = 3'd0;
    localparam pcSrcT PC_SRC_REG    = 3'd1;
    localparam pcSrcT PC_SRC_ALUOUT = 3'd2;
    localparam pcSrcT PC_SRC_VECTOR = 3'd3;    // Handler address read from memory

    localparam regDestT REG_DEST_RT = 2'd0;
    localparam regDestT REG_DEST_RD = 2'd1;
    localparam regDestT REG_DEST_RA = 2'd2;
    localparam regDestT REG_DEST_SP = 2'd3;

    localparam memToRegT MEM_TO_REG_ALU    = 3'd0;
    localparam memToRegT MEM_TO_REG_MEM    = 3'd1;
    localparam memToRegT MEM_TO_REG_SPINIT = 3'd2;
    localparam memToRegT MEM_TO_REG_PC     = 3'd4;

    localparam sizeT SIZE_BYTE       = 3'd0;
    localparam sizeT SIZE_WORD_STORE = 3'd1;
    localparam sizeT SIZE_HALF       = 3'd2;
    localparam sizeT SIZE_LOAD_BYTE  = 3'd3;
    localparam sizeT SIZE_LOAD_WORD  = 3'd4;
    localparam sizeT SIZE_LOAD_HALF  = 3'd5;
    localparam sizeT SIZE_EXCEPTION  = 3'd6;

    localparam addrSelT ADDR_PC           = 3'd0;
    localparam addrSelT ADDR_OVERFLOW_VEC = 3'd1;
    localparam addrSelT ADDR_INVALID_VEC  = 3'd3;

    // Lengths of the multi-cycle states
    localparam timerT RESET_CYCLES = 3'd2;
    localparam timerT FETCH_CYCLES = 3'd2;
    localparam timerT MEM_CYCLES   = 3'd2;
    localparam timerT JAL_CYCLES   = 3'd2;
    localparam timerT EXC_CYCLES   = 3'd5;

    typedef enum logic [4:0] {
        ST_RESET, ST_FETCH1, ST_FETCH2, ST_DECODE,
        ST_ALU_R, ST_ALU_I, ST_SAVE_RD, ST_SAVE_RT,
        ST_JR, ST_SAVE_PC,
        ST_BRANCH_CALC, ST_BRANCH_TEST, ST_COND_SAVE_PC,
        ST_MEM_CALC, ST_READ_MEM, ST_LOAD, ST_STORE,
        ST_JUMP, ST_JAL,
        ST_INVALID, ST_OVERFLOW, ST_EXCEPTION
    } stateT;

    typedef struct packed {
        stateT entryState;
        aluOpT aluOp;
        sizeT  loadSize;
        sizeT  storeSize;
        logic  storeDirect;    // sw writes without the read phase
        logic  isStore;
    } decodedT;

    typedef struct packed {
        logic     pcWriteCond;
        logic     pcWrite;
        logic     iOrD;
        addrSelT  srcAddr;
        logic     memWrite;
        memToRegT memToReg;
        sizeT     sizeHandler;
        logic     irWrite;
        logic     dataSource;
        logic     epcWrite;
        regDestT  regDest;
        logic     regWrite;
        srcASelT  aluSrcA;
        srcBSelT  aluSrcB;
        aluOpT    aluOp;
        pcSrcT    pcSource;
    } controlWordT;

endpackage

/* hdl/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder import controlPkg::*;
(
    input  opcodeT  opcode,
    input  functT   funct,
    output decodedT decoded
);

    always_comb
    begin
        decoded = '0;
        decoded.entryState = ST_INVALID;   // Unknown codes trap
        decoded.aluOp = ALU_LOAD;
        case (opcode)
            OP_RTYPE:
            begin
                decoded.entryState = ST_ALU_R;
                case (funct)
                    FN_ADD:  decoded.aluOp = ALU_OADD;
                    FN_SUB:  decoded.aluOp = ALU_SUB;
                    FN_AND:  decoded.aluOp = ALU_AND;
                    FN_OR:   decoded.aluOp = ALU_OR;
                    FN_SLT:  decoded.aluOp = ALU_CMP;
                    FN_JR:   decoded.entryState = ST_JR;   // Target passes through ALU
                    default: decoded.entryState = ST_INVALID;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI:
            begin
                decoded.entryState = ST_ALU_I;
                decoded.aluOp = (opcode == OP_ADDI)  ? ALU_OADD :
                                (opcode == OP_ADDIU) ? ALU_SADD : ALU_CMP;
            end
            OP_BEQ, OP_BNE, OP_BLE, OP_BGT:
            begin
                decoded.entryState = ST_BRANCH_CALC;
                decoded.aluOp = (opcode == OP_BEQ) ? ALU_EQ :
                                (opcode == OP_BNE) ? ALU_NE :
                                (opcode == OP_BLE) ? ALU_LE : ALU_GT;
            end
            OP_LW, OP_LH, OP_LB:
            begin
                decoded.entryState = ST_MEM_CALC;
                decoded.aluOp = ALU_OADD;   // Base plus offset
                decoded.loadSize = (opcode == OP_LW) ? SIZE_LOAD_WORD :
                                   (opcode == OP_LH) ? SIZE_LOAD_HALF : SIZE_LOAD_BYTE;
            end
            OP_SW, OP_SH, OP_SB:
            begin
                decoded.entryState = ST_MEM_CALC;
                decoded.aluOp = ALU_OADD;
                decoded.isStore = 1'b1;
                decoded.storeDirect = (opcode == OP_SW);   // Partial stores merge first
                decoded.storeSize = (opcode == OP_SW) ? SIZE_WORD_STORE :
                                    (opcode == OP_SH) ? SIZE_HALF : SIZE_BYTE;
            end
            OP_J:    decoded.entryState = ST_JUMP;
            OP_JAL:  decoded.entryState = ST_JAL;
            default: decoded.entryState = ST_INVALID;
        endcase
    end

endmodule

/* hdl/waitTimer.sv */
`timescale 1ns/10ps

module waitTimer import controlPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  load,
    input  timerT length,
    output logic  done
);

    timerT count;   // Cycles still to go after the current one

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (load)
            count <= length - 3'd1;
        else if (count != '0)
            count <= count - 3'd1;
    end

    // A length of one finishes in the load cycle itself
    assign done = load ? (length == 3'd1) : (count == 3'd1);

    // An idle counter stays idle until the next load
    assert property (@(posedge clk) disable iff (reset)
        (!load && count == '0) |=> (load || !done));

endmodule

/* hdl/controlFsm.sv */
`timescale 1ns/10ps

module controlFsm import controlPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  decodedT decoded,
    input  logic    overflow,
    output stateT   state,
    output decodedT curInstr
);

    stateT nextState;
    logic  firstCycle;      // State was entered this cycle
    logic  stateDone;
    timerT stateLength;
    logic  checkOverflow;

    waitTimer timer
    (
        .clk    (clk),
        .reset  (reset),
        .load   (firstCycle),
        .length (stateLength),
        .done   (stateDone)
    );

    always_comb
    begin
        case (state)
            ST_RESET:                 stateLength = RESET_CYCLES;
            ST_FETCH1:                stateLength = FETCH_CYCLES;   // Memory latency
            ST_READ_MEM, ST_LOAD:     stateLength = MEM_CYCLES;
            ST_JAL:                   stateLength = JAL_CYCLES;
            ST_INVALID, ST_OVERFLOW:  stateLength = EXC_CYCLES;
            default:                  stateLength = 3'd1;
        endcase
    end

    // Trap states and reset ignore the flag
    assign checkOverflow = !(state inside {ST_RESET, ST_INVALID, ST_OVERFLOW, ST_EXCEPTION});

    always_comb
    begin
        nextState = state;
        if (checkOverflow && overflow)
            nextState = ST_OVERFLOW;
        else if (stateDone)
        begin
            case (state)
                ST_RESET:        nextState = ST_FETCH1;
                ST_FETCH1:       nextState = ST_FETCH2;
                ST_FETCH2:       nextState = ST_DECODE;
                ST_DECODE:       nextState = decoded.entryState;
                ST_ALU_R:        nextState = ST_SAVE_RD;
                ST_ALU_I:        nextState = ST_SAVE_RT;
                ST_JR:           nextState = ST_SAVE_PC;
                ST_BRANCH_CALC:  nextState = ST_BRANCH_TEST;
                ST_BRANCH_TEST:  nextState = ST_COND_SAVE_PC;
                ST_MEM_CALC:     nextState = curInstr.storeDirect ? ST_STORE : ST_READ_MEM;
                ST_READ_MEM:     nextState = curInstr.isStore ? ST_STORE : ST_LOAD;
                ST_INVALID:      nextState = ST_EXCEPTION;
                ST_OVERFLOW:     nextState = ST_EXCEPTION;
                default:         nextState = ST_FETCH1;   // Last state of every sequence
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_RESET;
            firstCycle <= 1'b1;
        end
        else
        begin
            state      <= nextState;
            firstCycle <= (nextState != state);
        end
    end

    // Instruction register contents are only valid during decode
    always_ff @(posedge clk)
    begin
        if (state == ST_DECODE)
            curInstr <= decoded;
    end

    assert property (@(posedge clk) disable iff (reset)
        state inside {[ST_RESET:ST_EXCEPTION]});

    assert property (@(posedge clk) disable iff (reset)
        (state == ST_LOAD) |-> !curInstr.isStore);

endmodule

/* hdl/controlWordGen.sv */
`timescale 1ns/10ps

module controlWordGen import controlPkg::*;
(
    input  stateT       state,
    input  decodedT     curInstr,
    output controlWordT ctrl
);

    always_comb
    begin
        ctrl = '0;
        ctrl.pcSource = PC_SRC_ALUOUT;
        case (state)
            ST_RESET:
            begin
                ctrl.regDest  = REG_DEST_SP;         // Stack pointer init
                ctrl.memToReg = MEM_TO_REG_SPINIT;
                ctrl.regWrite = 1'b1;
            end
            ST_FETCH1:
            begin
                ctrl.iOrD    = 1'b0;
                ctrl.srcAddr = ADDR_PC;
            end
            ST_FETCH2:
            begin
                ctrl.aluSrcA = SRC_A_PC;             // PC + 4
                ctrl.aluSrcB = SRC_B_FOUR;
                ctrl.aluOp   = ALU_OADD;
                ctrl.irWrite = 1'b1;
            end
            ST_DECODE:  ctrl.pcWrite = 1'b1;
            ST_ALU_R, ST_JR, ST_BRANCH_TEST, ST_COND_SAVE_PC:
            begin
                ctrl.aluSrcA = SRC_A_REG;
                ctrl.aluSrcB = SRC_B_REG;
                if (state != ST_COND_SAVE_PC)
                    ctrl.aluOp = curInstr.aluOp;
                ctrl.pcWriteCond = (state == ST_BRANCH_TEST);
                if (state == ST_JR)
                begin
                    ctrl.pcSource = PC_SRC_REG;
                    ctrl.pcWrite  = 1'b1;
                end
            end
            ST_ALU_I, ST_MEM_CALC, ST_READ_MEM, ST_STORE:
            begin
                ctrl.aluSrcA = SRC_A_REG;            // Register plus immediate
                ctrl.aluSrcB = SRC_B_IMM;
                ctrl.aluOp   = curInstr.aluOp;
                ctrl.iOrD    = (state == ST_READ_MEM) || (state == ST_STORE);
                if (state == ST_STORE)
                begin
                    ctrl.sizeHandler = curInstr.storeSize;
                    ctrl.dataSource  = 1'b1;
                    ctrl.memWrite    = 1'b1;
                end
            end
            ST_SAVE_RD, ST_SAVE_RT:
            begin
                ctrl.memToReg = MEM_TO_REG_ALU;
                ctrl.regDest  = (state == ST_SAVE_RD) ? REG_DEST_RD : REG_DEST_RT;
                ctrl.regWrite = 1'b1;
            end
            ST_SAVE_PC:
            begin
                ctrl.pcSource = PC_SRC_REG;
                ctrl.pcWrite  = 1'b1;
            end
            ST_BRANCH_CALC:
            begin
                ctrl.aluSrcA = SRC_A_PC;             // Branch target into ALUOut
                ctrl.aluSrcB = SRC_B_BRANCH;
                ctrl.aluOp   = ALU_OADD;
            end
            ST_LOAD:
            begin
                ctrl.iOrD        = 1'b1;
                ctrl.sizeHandler = curInstr.loadSize;
                ctrl.memToReg    = MEM_TO_REG_MEM;
                ctrl.regDest     = REG_DEST_RT;
                ctrl.regWrite    = 1'b1;
            end
            ST_JUMP, ST_JAL:
            begin
                ctrl.pcSource = PC_SRC_JUMP;
                ctrl.pcWrite  = 1'b1;
                if (state == ST_JAL)
                begin
                    ctrl.regDest  = REG_DEST_RA;     // Link address
                    ctrl.memToReg = MEM_TO_REG_PC;
                    ctrl.regWrite = 1'b1;
                end
            end
            ST_INVALID, ST_OVERFLOW:
            begin
                ctrl.srcAddr = (state == ST_INVALID) ? ADDR_INVALID_VEC : ADDR_OVERFLOW_VEC;
                ctrl.sizeHandler = SIZE_EXCEPTION;
                ctrl.pcSource    = PC_SRC_VECTOR;
                ctrl.pcWrite     = 1'b1;
                ctrl.epcWrite    = 1'b1;             // Save faulting PC
            end
            ST_EXCEPTION:
            begin
                ctrl.sizeHandler = SIZE_EXCEPTION;
                ctrl.pcSource    = PC_SRC_VECTOR;
            end
            default:
            begin
                ctrl.pcSource = PC_SRC_ALUOUT;
            end
        endcase
    end

    always_comb
    begin
        assert final (!ctrl.epcWrite || ctrl.pcWrite);
        assert final (!(ctrl.irWrite && ctrl.regWrite));
    end

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit import controlPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  opcodeT      opcode,
    input  functT       funct,
    input  logic        overflow,
    output controlWordT ctrl
);

    decodedT decoded;
    decodedT curInstr;    // Latched at decode
    stateT   state;

    instrDecoder decoder
    (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    controlFsm fsm
    (
        .clk      (clk),
        .reset    (reset),
        .decoded  (decoded),
        .overflow (overflow),
        .state    (state),
        .curInstr (curInstr)
    );

    controlWordGen wordGen
    (
        .state    (state),
        .curInstr (curInstr),
        .ctrl     (ctrl)
    );

endmodule

/* verif/controlRef.svh */
`ifndef CONTROL_REF_SVH
`define CONTROL_REF_SVH

// First state after decode, straight from the instruction set table
function automatic stateT entryOf(input opcodeT op, input functT fn);
    stateT entry;
    entry = ST_INVALID;
    case (op)
        OP_RTYPE:
        begin
            case (fn)
                FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: entry = ST_ALU_R;
                FN_JR:   entry = ST_JR;
                default: entry = ST_INVALID;
            endcase
        end
        OP_ADDI, OP_ADDIU, OP_SLTI:                entry = ST_ALU_I;
        OP_BEQ, OP_BNE, OP_BLE, OP_BGT:            entry = ST_BRANCH_CALC;
        OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB:  entry = ST_MEM_CALC;
        OP_J:    entry = ST_JUMP;
        OP_JAL:  entry = ST_JAL;
        default: entry = ST_INVALID;
    endcase
    return entry;
endfunction

function automatic aluOpT aluOpFor(input opcodeT op, input functT fn);
    aluOpT result;
    result = ALU_LOAD;
    case (op)
        OP_RTYPE:
        begin
            case (fn)
                FN_ADD:  result = ALU_OADD;
                FN_SUB:  result = ALU_SUB;
                FN_AND:  result = ALU_AND;
                FN_OR:   result = ALU_OR;
                FN_SLT:  result = ALU_CMP;
                default: result = ALU_LOAD;   // jr passes the register through
            endcase
        end
        OP_ADDI:  result = ALU_OADD;
        OP_ADDIU: result = ALU_SADD;
        OP_SLTI:  result = ALU_CMP;
        OP_BEQ:   result = ALU_EQ;
        OP_BNE:   result = ALU_NE;
        OP_BLE:   result = ALU_LE;
        OP_BGT:   result = ALU_GT;
        OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB: result = ALU_OADD;
        default:  result = ALU_LOAD;
    endcase
    return result;
endfunction

function automatic sizeT sizeFor(input opcodeT op);
    sizeT size;
    case (op)
        OP_LW:   size = SIZE_LOAD_WORD;
        OP_LH:   size = SIZE_LOAD_HALF;
        OP_LB:   size = SIZE_LOAD_BYTE;
        OP_SW:   size = SIZE_WORD_STORE;
        OP_SH:   size = SIZE_HALF;
        default: size = SIZE_BYTE;
    endcase
    return size;
endfunction

// Total cycles from the first fetch cycle to the last state of the instruction
function automatic int sequenceLength(input opcodeT op, input functT fn, input bit ovf);
    int len;
    if (ovf)
        return 11;   // Execute, 5 trap cycles, exception cycle
    case (entryOf(op, fn))
        ST_BRANCH_CALC: len = 7;
        ST_MEM_CALC:    len = (op == OP_SW) ? 6 : (op == OP_SH || op == OP_SB) ? 8 : 9;
        ST_JUMP:        len = 5;
        ST_INVALID:     len = 10;
        default:        len = 6;
    endcase
    return len;
endfunction

// State expected in cycle k of the instruction
function automatic stateT stateAt(input opcodeT op, input functT fn, input bit ovf, input int k);
    stateT entry;
    stateT s;
    int j;
    entry = entryOf(op, fn);
    j = k - 4;
    if (k < 2)
        s = ST_FETCH1;
    else if (k == 2)
        s = ST_FETCH2;
    else if (k == 3)
        s = ST_DECODE;
    else if (j == 0)
        s = entry;
    else if (ovf)
        s = (j < 6) ? ST_OVERFLOW : ST_EXCEPTION;
    else
    begin
        case (entry)
            ST_ALU_R:       s = ST_SAVE_RD;
            ST_ALU_I:       s = ST_SAVE_RT;
            ST_JR:          s = ST_SAVE_PC;
            ST_BRANCH_CALC: s = (j == 1) ? ST_BRANCH_TEST : ST_COND_SAVE_PC;
            ST_MEM_CALC:
            begin
                if (op == OP_SW)
                    s = ST_STORE;
                else if (j < 3)
                    s = ST_READ_MEM;
                else if (op == OP_SH || op == OP_SB)
                    s = ST_STORE;
                else
                    s = ST_LOAD;
            end
            ST_INVALID:     s = (j < 5) ? ST_INVALID : ST_EXCEPTION;
            default:        s = entry;   // j and jal stay put
        endcase
    end
    return s;
endfunction

function automatic controlWordT wordFor(input stateT s, input opcodeT op, input functT fn);
    controlWordT w;
    w = '0;
    w.pcSource = PC_SRC_ALUOUT;
    case (s)
        ST_RESET:
        begin
            w.regDest  = REG_DEST_SP;
            w.memToReg = MEM_TO_REG_SPINIT;
            w.regWrite = 1'b1;
        end
        ST_FETCH2:
        begin
            w.aluSrcB = SRC_B_FOUR;   // PC plus four
            w.aluOp   = ALU_OADD;
            w.irWrite = 1'b1;
        end
        ST_DECODE:
            w.pcWrite = 1'b1;
        ST_ALU_R, ST_BRANCH_TEST, ST_COND_SAVE_PC, ST_JR:
        begin
            w.aluSrcA = SRC_A_REG;
            w.aluSrcB = SRC_B_REG;
            if (s != ST_COND_SAVE_PC)
                w.aluOp = aluOpFor(op, fn);
            w.pcWriteCond = (s == ST_BRANCH_TEST);
            if (s == ST_JR)
            begin
                w.pcSource = PC_SRC_REG;
                w.pcWrite  = 1'b1;
            end
        end
        ST_ALU_I, ST_MEM_CALC, ST_READ_MEM, ST_STORE:
        begin
            w.aluSrcA = SRC_A_REG;
            w.aluSrcB = SRC_B_IMM;
            w.aluOp   = aluOpFor(op, fn);
            w.iOrD    = (s == ST_READ_MEM || s == ST_STORE);
            if (s == ST_STORE)
            begin
                w.sizeHandler = sizeFor(op);
                w.dataSource  = 1'b1;
                w.memWrite    = 1'b1;
            end
        end
        ST_SAVE_RD, ST_SAVE_RT:
        begin
            w.regDest  = (s == ST_SAVE_RD) ? REG_DEST_RD : REG_DEST_RT;
            w.regWrite = 1'b1;
        end
        ST_SAVE_PC:
        begin
            w.pcSource = PC_SRC_REG;
            w.pcWrite  = 1'b1;
        end
        ST_BRANCH_CALC:
        begin
            w.aluSrcB = SRC_B_BRANCH;
            w.aluOp   = ALU_OADD;
        end
        ST_LOAD:
        begin
            w.iOrD        = 1'b1;
            w.sizeHandler = sizeFor(op);
            w.memToReg    = MEM_TO_REG_MEM;
            w.regWrite    = 1'b1;
        end
        ST_JUMP, ST_JAL:
        begin
            w.pcSource = PC_SRC_JUMP;
            w.pcWrite  = 1'b1;
            if (s == ST_JAL)
            begin
                w.regDest  = REG_DEST_RA;   // Link register
                w.memToReg = MEM_TO_REG_PC;
                w.regWrite = 1'b1;
            end
        end
        ST_INVALID, ST_OVERFLOW:
        begin
            w.srcAddr     = (s == ST_INVALID) ? ADDR_INVALID_VEC : ADDR_OVERFLOW_VEC;
            w.sizeHandler = SIZE_EXCEPTION;
            w.pcSource    = PC_SRC_VECTOR;
            w.pcWrite     = 1'b1;
            w.epcWrite    = 1'b1;
        end
        ST_EXCEPTION:
        begin
            w.sizeHandler = SIZE_EXCEPTION;
            w.pcSource    = PC_SRC_VECTOR;
        end
        default:
            w.pcSource = PC_SRC_ALUOUT;   // Fetch1 reads at the PC
    endcase
    return w;
endfunction

`endif

/* verif/controlUnitTb.sv */
`timescale 1ns/10ps

module controlUnitTb import controlPkg::*;
();

    localparam int NUM_INSTR  = 80;
    localparam int RESET_HOLD = 8;

    logic        clk;
    logic        reset;
    opcodeT      opcode;
    functT       funct;
    logic        overflow;
    controlWordT ctrl;

    opcodeT      opList [NUM_INSTR];
    functT       fnList [NUM_INSTR];
    bit          ovfList [NUM_INSTR];
    controlWordT expQ [$];   // One word per cycle after reset release
    controlWordT expWord;
    bit          checking;
    bit          irSeen;     // irWrite seen in the cycle just ending
    bit          raiseNext;
    int          instrIdx;
    int          cycleCount;
    int          cycleLimit;

    opcodeT otherOps [15] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_BEQ, OP_BNE, OP_BLE, OP_BGT,
                              OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB, OP_J, OP_JAL};
    functT  rtypeFns [6]  = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_JR};

    `include "controlRef.svh"

    controlUnit UUT
    (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, actual,
                     expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Only add, sub and addi can trap on overflow
    function automatic bit canOverflow(input opcodeT op, input functT fn);
        return (op == OP_RTYPE && (fn == FN_ADD || fn == FN_SUB)) || op == OP_ADDI;
    endfunction

    task automatic pickInstr(input int i);
        int draw;
        draw = $urandom % 8;
        if (draw == 0)
        begin
            opList[i] = $urandom % 64;
            fnList[i] = $urandom % 64;
            while (entryOf(opList[i], fnList[i]) != ST_INVALID)
            begin
                opList[i] = $urandom % 64;
                fnList[i] = $urandom % 64;
            end
        end
        else if (draw < 3)
        begin
            opList[i] = OP_RTYPE;
            fnList[i] = rtypeFns[$urandom % 6];
        end
        else
        begin
            opList[i] = otherOps[$urandom % 15];
            fnList[i] = $urandom % 64;
        end
        ovfList[i] = canOverflow(opList[i], fnList[i]) && ($urandom % 3 == 0);
    endtask

    initial
    begin
        int i;
        int k;
        clk        = 1'b0;
        reset      = 1'b1;
        opcode     = '0;
        funct      = '0;
        overflow   = 1'b0;
        checking   = 1'b0;
        irSeen     = 1'b0;
        raiseNext  = 1'b0;
        instrIdx   = 0;
        cycleCount = 0;
        void'($urandom(30384));
        repeat (2) expQ.push_back(wordFor(ST_RESET, '0, '0));
        for (i = 0; i < NUM_INSTR; i++)
        begin
            pickInstr(i);
            for (k = 0; k < sequenceLength(opList[i], fnList[i], ovfList[i]); k++)
                expQ.push_back(wordFor(stateAt(opList[i], fnList[i], ovfList[i], k),
                                       opList[i], fnList[i]));
        end
        cycleLimit = RESET_HOLD + expQ.size() + 20;
        repeat (RESET_HOLD) @(posedge clk);
        reset <= 1'b0;
        checking = 1'b1;
        while (expQ.size() != 0)
            @(posedge clk);
        if (instrIdx != NUM_INSTR)
        begin
            $display("Only %0d of %0d instructions were presented", instrIdx, NUM_INSTR);
            $display("test failed");
            $fatal(1);
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

    // Instruction register model plus overflow in the execute cycle
    always @(posedge clk)
    begin
        overflow <= 1'b0;
        if (irSeen && instrIdx < NUM_INSTR)
        begin
            opcode    <= opList[instrIdx];
            funct     <= fnList[instrIdx];
            raiseNext = ovfList[instrIdx];
            instrIdx  = instrIdx + 1;
        end
        else if (raiseNext)
        begin
            overflow  <= 1'b1;   // Decode is over, execute starts
            raiseNext = 1'b0;
        end
    end

    always @(negedge clk)
    begin
        if (checking && expQ.size() != 0)
        begin
            expWord = expQ.pop_front();
            checkValue("pcWriteCond", ctrl.pcWriteCond, expWord.pcWriteCond);
            checkValue("pcWrite", ctrl.pcWrite, expWord.pcWrite);
            checkValue("iOrD", ctrl.iOrD, expWord.iOrD);
            checkValue("srcAddr", ctrl.srcAddr, expWord.srcAddr);
            checkValue("memWrite", ctrl.memWrite, expWord.memWrite);
            checkValue("memToReg", ctrl.memToReg, expWord.memToReg);
            checkValue("sizeHandler", ctrl.sizeHandler, expWord.sizeHandler);
            checkValue("irWrite", ctrl.irWrite, expWord.irWrite);
            checkValue("dataSource", ctrl.dataSource, expWord.dataSource);
            checkValue("epcWrite", ctrl.epcWrite, expWord.epcWrite);
            checkValue("regDest", ctrl.regDest, expWord.regDest);
            checkValue("regWrite", ctrl.regWrite, expWord.regWrite);
            checkValue("aluSrcA", ctrl.aluSrcA, expWord.aluSrcA);
            checkValue("aluSrcB", ctrl.aluSrcB, expWord.aluSrcB);
            checkValue("aluOp", ctrl.aluOp, expWord.aluOp);
            checkValue("pcSource", ctrl.pcSource, expWord.pcSource);
        end
        irSeen = (ctrl.irWrite === 1'b1);
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout after %0d cycles with %0d cycles left to check", cycleCount,
                     expQ.size());
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

/* project.f */
+incdir+verif
hdl/controlPkg.sv
hdl/instrDecoder.sv
hdl/waitTimer.sv
hdl/controlFsm.sv
hdl/controlWordGen.sv
hdl/controlUnit.sv
verif/controlUnitTb.sv
